// ==== build.f ====
+incdir+include
source/fft_num_pkg.sv
source/fft_ctrl_pkg.sv
source/sample_wr_if.sv
source/frame_rd_if.sv
source/sample_collector.sv
source/frame_store.sv
source/fft_butterfly.sv
source/fft_engine.sv
source/fft_top.sv
test/tb_fft.sv

// ==== include/fft_defs.svh ====
// Sizes shared by the FFT datapath, the sample store and the testbench.
// Include wherever a width, point count or slot count is needed.

`ifndef FFT_DEFS_SVH
`define FFT_DEFS_SVH

// frame geometry
`define FFT_POINTS   16
`define FFT_STAGES   4

// sample and word formats, Q16.16 internally
`define SAMPLE_W     16
`define WORD_W       32
`define FRAC_W       16
`define PAD_W        8

// frame store depth, also the credit count
`define FRAME_SLOTS  2

`endif

// ==== source/fft_butterfly.sv ====
// Radix-2 decimation-in-frequency butterfly on Q16.16 complex words.
// sum = a + b, diff_w = (a - b) * w, with the multiply skipped on bypass_w.

`timescale 1ns/1ps
`include "fft_defs.svh"

module fft_butterfly (
    input  fft_num_pkg::cplx_t a,
    input  fft_num_pkg::cplx_t b,
    input  fft_num_pkg::cplx_t w,
    input  logic               bypass_w,
    output fft_num_pkg::cplx_t sum,
    output fft_num_pkg::cplx_t diff_w
);
    import fft_num_pkg::*;

    cplx_t                       d;
    logic signed [2*`WORD_W-1:0] p_rr;
    logic signed [2*`WORD_W-1:0] p_ii;
    logic signed [2*`WORD_W-1:0] p_ri;
    logic signed [2*`WORD_W-1:0] p_ir;
    cplx_t                       prod;

    assign sum.re = a.re + b.re;
    assign sum.im = a.im + b.im;

    assign d.re = a.re - b.re;
    assign d.im = a.im - b.im;

    assign p_rr = d.re * w.re;
    assign p_ii = d.im * w.im;
    assign p_ri = d.re * w.im;
    assign p_ir = d.im * w.re;

    // back to Q16.16, bits 47..16 of each product
    assign prod.re = p_rr[`FRAC_W +: `WORD_W] - p_ii[`FRAC_W +: `WORD_W];
    assign prod.im = p_ri[`FRAC_W +: `WORD_W] + p_ir[`FRAC_W +: `WORD_W];

    assign diff_w = bypass_w ? d : prod;

endmodule

// ==== source/fft_ctrl_pkg.sv ====
// State encodings of the sample collector and the FFT engine.
// Imported by the control logic of both blocks.

package fft_ctrl_pkg;

    typedef enum logic {
        COLLECT,
        WAIT_CREDIT
    } coll_state_e;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        STAGE1,
        STAGE2,
        STAGE3,
        STAGE4,
        STREAM
    } fft_state_e;

endpackage

// ==== source/fft_engine.sv ====
// 16-point DIF FFT engine. Takes one frame from the store, runs four
// in-place butterfly stages with eight butterflies in parallel, then
// streams the 16 bins in natural order with done on the last one.
// Each frame keeps the engine busy for 22 cycles.

`timescale 1ns/1ps
`include "fft_defs.svh"

module fft_engine (
    input  logic                 clk,
    input  logic                 rst,
    frame_rd_if.engine           rd,
    output logic                 fft_valid,
    output logic [`SAMPLE_W-1:0] fft_real,
    output logic [`SAMPLE_W-1:0] fft_imag,
    output logic                 done
);
    import fft_num_pkg::*;
    import fft_ctrl_pkg::*;

    localparam int N_BF    = `FFT_POINTS / 2;
    localparam int OUT_LSB = `FRAC_W - `PAD_W;

    fft_state_e state;
    fft_state_e state_nxt;
    bin_idx_t   bin_cnt;
    logic [1:0] stage_idx;
    bin_idx_t   span;
    bin_idx_t   mask;
    logic       in_stage;
    cplx_t      work [`FFT_POINTS];
    cplx_t      out_bin;

    bin_idx_t   idx_a   [N_BF];
    bin_idx_t   idx_b   [N_BF];
    cplx_t      bf_sum  [N_BF];
    cplx_t      bf_diff [N_BF];

    function automatic bin_idx_t bit_rev(input bin_idx_t v);
        bin_idx_t r;
        for (int n = 0; n < `FFT_STAGES; n++) begin
            r[n] = v[`FFT_STAGES-1-n];
        end
        return r;
    endfunction

    ////////////////////
    // control
    ////////////////////

    assign rd.take = (state == IDLE) && rd.avail;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (rd.avail) begin
                    state_nxt = LOAD;
                end
            end
            LOAD:   state_nxt = STAGE1;
            STAGE1: state_nxt = STAGE2;
            STAGE2: state_nxt = STAGE3;
            STAGE3: state_nxt = STAGE4;
            STAGE4: state_nxt = STREAM;
            STREAM: begin
                if (bin_cnt == bin_idx_t'(`FFT_POINTS - 1)) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            bin_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == LOAD) begin
                bin_cnt <= '0;
            end else if (state == STREAM) begin
                bin_cnt <= bin_cnt + 1'b1;
            end
        end
    end

    ////////////////////
    // butterfly array
    ////////////////////

    always_comb begin
        in_stage = 1'b1;
        case (state)
            STAGE1:  stage_idx = 2'd0;
            STAGE2:  stage_idx = 2'd1;
            STAGE3:  stage_idx = 2'd2;
            STAGE4:  stage_idx = 2'd3;
            default: begin
                stage_idx = 2'd0;
                in_stage  = 1'b0;
            end
        endcase
    end

    // span 8, 4, 2, 1
    assign span = bin_idx_t'(N_BF) >> stage_idx;
    assign mask = span - 1'b1;

    for (genvar k = 0; k < N_BF; k++) begin : g_bf
        bin_idx_t   lo;
        bin_idx_t   grp;
        logic [2:0] tw_idx;

        // k split into group base and position inside the group
        assign lo       = bin_idx_t'(k) & mask;
        assign grp      = bin_idx_t'(k) - lo;
        assign idx_a[k] = (grp << 1) + lo;
        assign idx_b[k] = idx_a[k] + span;
        assign tw_idx   = lo[2:0] << stage_idx;

        fft_butterfly i_bf (
            .a        (work[idx_a[k]]),
            .b        (work[idx_b[k]]),
            .w        (TWIDDLE[tw_idx]),
            .bypass_w (state == STAGE4),
            .sum      (bf_sum[k]),
            .diff_w   (bf_diff[k])
        );
    end

    // frame is captured on the take edge, the store frees the slot there
    always_ff @(posedge clk) begin
        if (rd.take) begin
            for (int i = 0; i < `FFT_POINTS; i++) begin
                work[i] <= '{re: rd.frame[i], im: '0};
            end
        end else if (in_stage) begin
            for (int k = 0; k < N_BF; k++) begin
                work[idx_a[k]] <= bf_sum[k];
                work[idx_b[k]] <= bf_diff[k];
            end
        end
    end

    ////////////////////
    // output stream
    ////////////////////

    // DIF leaves the bins in bit-reversed order
    assign out_bin   = work[bit_rev(bin_cnt)];
    assign fft_valid = (state == STREAM);
    assign done      = fft_valid && (bin_cnt == bin_idx_t'(`FFT_POINTS - 1));
    assign fft_real  = out_bin.re[OUT_LSB +: `SAMPLE_W];
    assign fft_imag  = out_bin.im[OUT_LSB +: `SAMPLE_W];

endmodule

// ==== source/fft_num_pkg.sv ====
// Numeric types of the FFT datapath and its twiddle factor table.
// Shared by the RTL blocks and the testbench reference model.

`include "fft_defs.svh"

package fft_num_pkg;

    // signed Q16.16
    typedef logic signed [`WORD_W-1:0] word_t;

    typedef struct packed {
        word_t re;
        word_t im;
    } cplx_t;

    // one frame of real samples
    typedef word_t frame_t [`FFT_POINTS];

    typedef logic [$clog2(`FFT_POINTS)-1:0] bin_idx_t;

    ////////////////////
    // twiddle factors
    ////////////////////

    // entry k is cos(2*pi*k/16) - j*sin(2*pi*k/16)
    localparam cplx_t TWIDDLE [`FFT_POINTS/2] = '{
        '{re: 32'h0001_0000, im: 32'h0000_0000},
        '{re: 32'h0000_EC83, im: 32'hFFFF_9E09},
        '{re: 32'h0000_B504, im: 32'hFFFF_4AFC},
        '{re: 32'h0000_61F7, im: 32'hFFFF_137D},
        '{re: 32'h0000_0000, im: 32'hFFFF_0000},
        '{re: 32'hFFFF_9E09, im: 32'hFFFF_137D},
        '{re: 32'hFFFF_4AFC, im: 32'hFFFF_4AFC},
        '{re: 32'hFFFF_137D, im: 32'hFFFF_9E09}
    };

endpackage

// ==== source/fft_top.sv ====
// Top level of the streaming 16-point FFT.
// Real samples go in on fir_d with a valid/ready pair; bins come out
// one per cycle on fft_real/fft_imag while fft_valid is high.

`timescale 1ns/1ps
`include "fft_defs.svh"

module fft_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`SAMPLE_W-1:0] fir_d,
    input  logic                 fir_valid,
    output logic                 fir_ready,
    output logic                 fft_valid,
    output logic [`SAMPLE_W-1:0] fft_real,
    output logic [`SAMPLE_W-1:0] fft_imag,
    output logic                 done
);

    sample_wr_if wr_bus ();
    frame_rd_if  rd_bus ();

    sample_collector i_collector (
        .clk       (clk),
        .rst       (rst),
        .fir_d     (fir_d),
        .fir_valid (fir_valid),
        .fir_ready (fir_ready),
        .wr        (wr_bus.collector)
    );

    frame_store i_store (
        .clk (clk),
        .rst (rst),
        .wr  (wr_bus.store),
        .rd  (rd_bus.store)
    );

    fft_engine i_engine (
        .clk       (clk),
        .rst       (rst),
        .rd        (rd_bus.engine),
        .fft_valid (fft_valid),
        .fft_real  (fft_real),
        .fft_imag  (fft_imag),
        .done      (done)
    );

endmodule

// ==== source/frame_rd_if.sv ====
// Read path from the frame store to the FFT engine.
// A whole frame is presented at once and taken with a one-cycle pulse.

`timescale 1ns/1ps

interface frame_rd_if;
    import fft_num_pkg::*;

    logic   avail;
    // oldest committed slot
    frame_t frame;
    logic   take;

    modport store (
        output avail,
        output frame,
        input  take
    );

    modport engine (
        input  avail,
        input  frame,
        output take
    );

endinterface

// ==== source/frame_store.sv ====
// Two-slot frame memory between the collector and the FFT engine.
// Slots are filled and drained in order; the oldest full slot is shown
// to the engine, and taking it hands a credit back to the collector.

`timescale 1ns/1ps
`include "fft_defs.svh"

module frame_store (
    input  logic       clk,
    input  logic       rst,
    sample_wr_if.store wr,
    frame_rd_if.store  rd
);
    import fft_num_pkg::*;

    localparam int PTR_W = $clog2(`FRAME_SLOTS);

    frame_t                  slot_mem [`FRAME_SLOTS];
    logic [PTR_W-1:0]        wr_slot;
    logic [PTR_W-1:0]        rd_slot;
    logic [`FRAME_SLOTS-1:0] full;

    function automatic logic [PTR_W-1:0] next_slot(input logic [PTR_W-1:0] s);
        logic [PTR_W-1:0] n;
        if (s == PTR_W'(`FRAME_SLOTS - 1)) begin
            n = '0;
        end else begin
            n = s + 1'b1;
        end
        return n;
    endfunction

    assign rd.avail = full[rd_slot];
    assign rd.frame = slot_mem[rd_slot];

    // freeing a slot is the credit
    assign wr.credit_return = rd.take && rd.avail;

    ////////////////////
    // slot data
    ////////////////////

    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            slot_mem[wr_slot][wr.wr_addr] <= wr.wr_data;
        end
    end

    ////////////////////
    // slot control
    ////////////////////

    // commit and take never hit the same slot while credits hold
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_slot <= '0;
            rd_slot <= '0;
            full    <= '0;
        end else begin
            if (wr.commit) begin
                full[wr_slot] <= 1'b1;
                wr_slot       <= next_slot(wr_slot);
            end
            if (wr.credit_return) begin
                full[rd_slot] <= 1'b0;
                rd_slot       <= next_slot(rd_slot);
            end
        end
    end

endmodule

// ==== source/sample_collector.sv ====
// Accepts the real sample stream, widens each sample to Q16.16 and writes
// it into the frame store. Frames are committed on their 16th sample and
// each commit spends one credit; fir_ready drops when none are left.

`timescale 1ns/1ps
`include "fft_defs.svh"

module sample_collector (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`SAMPLE_W-1:0] fir_d,
    input  logic                 fir_valid,
    output logic                 fir_ready,
    sample_wr_if.collector       wr
);
    import fft_num_pkg::*;
    import fft_ctrl_pkg::*;

    localparam int CRED_W = $clog2(`FRAME_SLOTS + 1);
    localparam int SIGN_W = `WORD_W - `SAMPLE_W - `PAD_W;

    coll_state_e       state;
    bin_idx_t          addr;
    logic [CRED_W-1:0] credits;
    logic [CRED_W-1:0] credits_nxt;
    logic              accept;

    assign fir_ready = (state == COLLECT);
    assign accept    = fir_valid && fir_ready;

    // sample lands in bits 23..8
    assign wr.wr_en   = accept;
    assign wr.wr_addr = addr;
    assign wr.wr_data = {{SIGN_W{fir_d[`SAMPLE_W-1]}}, fir_d, {`PAD_W{1'b0}}};
    assign wr.commit  = accept && (addr == bin_idx_t'(`FFT_POINTS - 1));

    always_comb begin
        credits_nxt = credits;
        if (wr.commit) begin
            credits_nxt = credits_nxt - 1'b1;
        end
        if (wr.credit_return) begin
            credits_nxt = credits_nxt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= COLLECT;
            addr    <= '0;
            credits <= CRED_W'(`FRAME_SLOTS);
        end else begin
            if (accept) begin
                addr <= addr + 1'b1;
            end
            credits <= credits_nxt;
            // only a commit can empty the count, so this moves at frame edges
            state   <= (credits_nxt != '0) ? COLLECT : WAIT_CREDIT;
        end
    end

endmodule

// ==== source/sample_wr_if.sv ====
// Write path from the sample collector into the frame store.
// Carries sample writes, the frame commit and the returning credits.

`timescale 1ns/1ps

interface sample_wr_if;
    import fft_num_pkg::*;

    logic     wr_en;
    bin_idx_t wr_addr;
    word_t    wr_data;
    logic     commit;
    // one pulse per freed slot
    logic     credit_return;

    modport collector (
        output wr_en, wr_addr, wr_data, commit,
        input  credit_return
    );

    modport store (
        input  wr_en, wr_addr, wr_data, commit,
        output credit_return
    );

endinterface

// ==== test/tb_fft.sv ====
// Testbench for the streaming 16-point FFT top level.
// Sends impulse, constant, gapped random and back-to-back random frames,
// checks every bin against a fixed-point model and checks output framing.

`timescale 1ns/1ps
`include "fft_defs.svh"

module tb_fft;
    import fft_num_pkg::*;

    localparam int N_RAND       = 20;
    localparam int N_BURST      = 8;
    localparam int FRAMES_TOTAL = 2 + N_RAND + N_BURST;
    localparam int CYCLE_LIMIT  = 30 * FRAMES_TOTAL + 200;

    logic                 clk;
    logic                 rst;
    logic [`SAMPLE_W-1:0] fir_d;
    logic                 fir_valid;
    logic                 fir_ready;
    logic                 fft_valid;
    logic [`SAMPLE_W-1:0] fft_real;
    logic [`SAMPLE_W-1:0] fft_imag;
    logic                 done;

    logic [15:0]          lfsr;
    word_t                acc_buf [`FFT_POINTS];
    logic [3:0]           acc_cnt;
    int                   beat;
    int                   frames_out;
    int                   cycles;
    bit                   ready_low_seen;
    int                   val_errs;
    int                   frame_errs;
    int                   flow_errs;

    string                kind_q [$];
    logic [15:0]          val_q [$];
    string                exp_name [$];
    logic [15:0]          exp_re [$];
    logic [15:0]          exp_im [$];

    fft_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .fir_d     (fir_d),
        .fir_valid (fir_valid),
        .fir_ready (fir_ready),
        .fft_valid (fft_valid),
        .fft_real  (fft_real),
        .fft_imag  (fft_imag),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    function automatic logic [3:0] bitrev4(input logic [3:0] k);
        return {k[0], k[1], k[2], k[3]};
    endfunction

    // Q16.16 product keeps bits 47..16
    function automatic word_t qmul(input word_t a, input word_t b);
        logic signed [63:0] p;
        p = a * b;
        return p[47:16];
    endfunction

    task automatic push_bin(input string name, input logic [15:0] re, input logic [15:0] im);
        exp_name.push_back(name);
        exp_re.push_back(re);
        exp_im.push_back(im);
    endtask

    // DIF model over spans 8 down to 1 with a bit-reversed readout
    task automatic push_model_bins(input string name);
        word_t xr [`FFT_POINTS];
        word_t xi [`FFT_POINTS];
        word_t dr;
        word_t di;
        int    h;
        int    a;
        int    b;
        int    t;
        for (int i = 0; i < `FFT_POINTS; i++) begin
            xr[i] = acc_buf[i];
            xi[i] = '0;
        end
        h = `FFT_POINTS / 2;
        for (int s = 1; s <= `FFT_STAGES; s++) begin
            for (int g = 0; g < `FFT_POINTS; g += 2 * h) begin
                for (int j = 0; j < h; j++) begin
                    a     = g + j;
                    b     = a + h;
                    t     = j * (8 / h);
                    dr    = xr[a] - xr[b];
                    di    = xi[a] - xi[b];
                    xr[a] = xr[a] + xr[b];
                    xi[a] = xi[a] + xi[b];
                    if (s == `FFT_STAGES) begin
                        xr[b] = dr;
                        xi[b] = di;
                    end else begin
                        xr[b] = qmul(dr, TWIDDLE[t].re) - qmul(di, TWIDDLE[t].im);
                        xi[b] = qmul(dr, TWIDDLE[t].im) + qmul(di, TWIDDLE[t].re);
                    end
                end
            end
            h = h / 2;
        end
        for (int k = 0; k < `FFT_POINTS; k++) begin
            t = bitrev4(4'(k));
            push_bin(name, xr[t][23:8], xi[t][23:8]);
        end
    endtask

    task automatic push_expected();
        string       kind;
        logic [15:0] v;
        logic [15:0] c16;
        kind = kind_q.pop_front();
        v    = val_q.pop_front();
        c16  = v << 4;
        for (int k = 0; k < `FFT_POINTS; k++) begin
            if (kind == "impulse") begin
                push_bin(kind, v, 16'h0000);
            end else if (kind == "constant") begin
                push_bin(kind, (k == 0) ? c16 : 16'h0000, 16'h0000);
            end
        end
        if (kind == "random") begin
            push_model_bins(kind);
        end
    endtask

    task automatic send_sample(input logic [15:0] s);
        fir_d     <= s;
        fir_valid <= 1'b1;
        do @(posedge clk); while (!fir_ready);
    endtask

    task automatic idle_cycles(input int n);
        fir_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic send_frame(input string kind, input logic [15:0] v, input bit gaps);
        logic [15:0] r;
        logic [15:0] s;
        kind_q.push_back(kind);
        val_q.push_back(v);
        for (int i = 0; i < `FFT_POINTS; i++) begin
            if (gaps) begin
                rand_bits(2, r);
                if (r == 0) begin
                    rand_bits(2, r);
                    idle_cycles(r + 1);
                end
            end
            if (kind == "random") begin
                rand_bits(16, s);
            end else if (kind == "impulse") begin
                s = (i == 0) ? v : 16'h0000;
            end else begin
                s = v;
            end
            send_sample(s);
        end
    endtask

    ////////////////////
    // monitors
    ////////////////////

    always @(posedge clk) begin
        if (rst) begin
            acc_cnt <= '0;
        end else if (fir_valid && fir_ready) begin
            acc_buf[acc_cnt] = {{8{fir_d[15]}}, fir_d, 8'h00};
            if (acc_cnt == 4'd15) begin
                push_expected();
            end
            acc_cnt <= acc_cnt + 1'b1;
        end
        if (!rst && !fir_ready) begin
            ready_low_seen = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst && fft_valid) begin
            assert (exp_re.size() != 0) else begin
                flow_errs++;
                $display("fft_valid is high but no frame was sent for it");
            end
            if (exp_re.size() != 0) begin
                assert (fft_real == exp_re[0] && fft_imag == exp_im[0]) else begin
                    val_errs++;
                    $display("error %s bin %0d: expected re %h im %h, actual re %h im %h",
                             exp_name[0], beat, exp_re[0], exp_im[0], fft_real, fft_imag);
                end
                void'(exp_name.pop_front());
                void'(exp_re.pop_front());
                void'(exp_im.pop_front());
            end
            assert (done == (beat == 15)) else begin
                frame_errs++;
                $display("error framing beat %0d: expected done %b, actual %b",
                         beat, (beat == 15), done);
            end
            if (beat == 15) begin
                frames_out++;
            end
            beat = (beat == 15) ? 0 : beat + 1;
        end else if (!rst) begin
            assert (beat == 0) else begin
                frame_errs++;
                $display("fft_valid dropped after %0d beats of a frame", beat);
                beat = 0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) done |-> fft_valid) else begin
        frame_errs++;
        $display("done is high while fft_valid is low");
    end

    // ready may only move right after a 16th accepted sample
    assert property (@(posedge clk) disable iff (rst) $changed(fir_ready) |-> acc_cnt == 0)
    else begin
        flow_errs++;
        $display("fir_ready changed in the middle of a frame");
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, not all frames came out", cycles);
            $display("test failed");
            $finish;
        end
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        rst            = 1'b1;
        fir_d          = '0;
        fir_valid      = 1'b0;
        lfsr           = 16'd17513;
        beat           = 0;
        frames_out     = 0;
        cycles         = 0;
        ready_low_seen = 1'b0;
        val_errs       = 0;
        frame_errs     = 0;
        flow_errs      = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!fft_valid && !done && fir_ready) else begin
            flow_errs++;
            $display("error reset: expected fft_valid 0 done 0 fir_ready 1, %s",
                     "actual below");
            $display("actual fft_valid %b done %b fir_ready %b", fft_valid, done, fir_ready);
        end

        send_frame("impulse", 16'h1234, 1'b0);
        send_frame("constant", 16'h0123, 1'b0);
        for (int f = 0; f < N_RAND; f++) begin
            send_frame("random", 16'h0000, 1'b1);
        end
        // back to back frames outrun the engine
        for (int f = 0; f < N_BURST; f++) begin
            send_frame("random", 16'h0000, 1'b0);
        end
        idle_cycles(2);
        while (exp_re.size() != 0 || fft_valid) begin
            @(posedge clk);
        end

        assert (ready_low_seen) else begin
            flow_errs++;
            $display("fir_ready never went low under continuous input");
        end
        assert (frames_out == FRAMES_TOTAL) else begin
            flow_errs++;
            $display("error frame count: expected %0d, actual %0d", FRAMES_TOTAL, frames_out);
        end

        $display("errors: value %0d, framing %0d, flow %0d", val_errs, frame_errs, flow_errs);
        if (val_errs == 0 && frame_errs == 0 && flow_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
